/* src/capture_pkg.sv */
`default_nettype none

package capture_pkg;

   // app command codes, as on the controller user port
   localparam logic [2:0] cmd_write = 3'd0;
   localparam logic [2:0] cmd_read = 3'd1;

   // one sample per app data beat
   localparam int sample_width = 32;
   // two samples per stored line
   localparam int line_width = 2 * sample_width;

   // app byte address
   localparam int addr_width = 30;
   // address step between lines
   localparam int line_bytes = 8;

   typedef logic [line_width-1:0] line_t;
   typedef logic [sample_width-1:0] sample_t;

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int p_depth = 16,
   parameter int p_threshold = 12
) (
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            wr_en,
   input  wire payload_t                  din,
   input  wire                            rd_en,
   output payload_t                       dout,
   output logic                           empty,
   output logic [$clog2(p_depth+1)-1:0]   level,
   output logic                           nearly_full,
   output logic                           overflow
);

   localparam int lw = $clog2(p_depth + 1);
   localparam int pw = (p_depth > 1) ? $clog2(p_depth) : 1;

   payload_t mem [p_depth];
   logic [pw-1:0] wr_ptr;
   logic [pw-1:0] rd_ptr;
   logic full;
   logic do_wr;
   logic do_rd;

   // wrap for depths that are not a power of two
   function automatic logic [pw-1:0] next_ptr(input logic [pw-1:0] ptr);
      return (ptr == pw'(p_depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full = (level == lw'(p_depth));
   assign empty = (level == '0);
   assign nearly_full = (level >= lw'(p_threshold));
   // writes into a full buffer are dropped
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;
   // head word visible before the pop
   assign dout = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level <= '0;
         overflow <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_rd) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_wr, do_rd})
            2'b10: level <= level + 1'b1;
            2'b01: level <= level - 1'b1;
            default: level <= level;
         endcase
         // sticky, cleared by reset only
         if (wr_en && full) begin
            overflow <= 1'b1;
         end
      end
   end

   a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd_en |-> !empty)
      else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

/* src/app_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module app_mem_model #(
   parameter int p_init_cycles = 64,
   parameter int p_ret_depth = 8,
   parameter int p_ret_threshold = 6,
   parameter int p_mem_lines = 256
) (
   input  wire                                   clk,
   input  wire                                   reset,
   input  wire [capture_pkg::addr_width-1:0]     app_addr,
   input  wire [2:0]                             app_cmd,
   input  wire                                   app_en,
   input  wire capture_pkg::sample_t             app_wdf_data,
   input  wire                                   app_wdf_wren,
   input  wire                                   app_wdf_end,
   output capture_pkg::sample_t                  app_rd_data,
   output logic                                  app_rd_data_valid,
   output logic                                  app_rd_data_end,
   output logic                                  app_rdy,
   output logic                                  init_calib_complete
);

   import capture_pkg::*;

   localparam int cw = $clog2(p_init_cycles + 1);
   localparam int iw = $clog2(p_mem_lines);
   localparam int sw = $clog2(line_bytes);
   localparam int rw = $clog2(p_ret_depth + 1);

   line_t mem [p_mem_lines];
   logic [cw-1:0] cal_cnt;
   logic [addr_width-1:0] line_num;
   logic [iw-1:0] line_idx;
   sample_t wbuf;
   logic wr_first;
   logic wr_last;
   logic rd_accept;
   logic rd_push;
   line_t rd_line;
   line_t ret_dout;
   logic ret_pop;
   logic ret_empty;
   logic [rw-1:0] ret_level;
   logic ret_nearly_full;
   logic [1:0] reply_phase;
   sample_t reply_lo;

   // calibration delay after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         cal_cnt <= '0;
         init_calib_complete <= 1'b0;
      end else if (!init_calib_complete) begin
         cal_cnt <= cal_cnt + 1'b1;
         if (cal_cnt == cw'(p_init_cycles - 1)) begin
            init_calib_complete <= 1'b1;
         end
      end
   end

   // throttle on return fifo fill
   assign app_rdy = init_calib_complete && !ret_nearly_full;

   // byte address to line index
   assign line_num = app_addr >> sw;
   assign line_idx = line_num[iw-1:0];

   assign wr_first = app_en && app_rdy && app_wdf_wren && !app_wdf_end &&
                     (app_cmd == cmd_write);
   // beat 2 goes through regardless of ready
   assign wr_last = app_en && app_wdf_wren && app_wdf_end;
   assign rd_accept = app_en && app_rdy && (app_cmd == cmd_read);

   // older sample lands in the upper half
   always_ff @(posedge clk) begin
      if (wr_first) begin
         wbuf <= app_wdf_data;
      end
      if (wr_last) begin
         mem[line_idx] <= {wbuf, app_wdf_data};
      end
      if (rd_accept) begin
         rd_line <= mem[line_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_push <= 1'b0;
      end else begin
         rd_push <= rd_accept;
      end
   end

   sync_fifo #(
      .payload_t   (line_t),
      .p_depth     (p_ret_depth),
      .p_threshold (p_ret_threshold)
   ) u_ret_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (rd_push),
      .din         (rd_line),
      .rd_en       (ret_pop),
      .dout        (ret_dout),
      .empty       (ret_empty),
      .level       (ret_level),
      .nearly_full (ret_nearly_full),
      .overflow    ()
   );

   // phase 0 pops or sits out the gap, phases 1 and 2 send the two beats
   assign ret_pop = (reply_phase == 2'd0) && !ret_empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         reply_phase <= 2'd0;
         app_rd_data_valid <= 1'b0;
         app_rd_data_end <= 1'b0;
      end else begin
         case (reply_phase)
            2'd0: begin
               app_rd_data_valid <= ret_pop;
               app_rd_data_end <= 1'b0;
               if (ret_pop) begin
                  reply_phase <= 2'd1;
               end
            end
            2'd1: begin
               app_rd_data_valid <= 1'b1;
               app_rd_data_end <= 1'b1;
               reply_phase <= 2'd2;
            end
            default: begin
               // gap cycle follows
               app_rd_data_valid <= 1'b0;
               app_rd_data_end <= 1'b0;
               reply_phase <= 2'd0;
            end
         endcase
      end
   end

   // upper half goes out on the pop and the lower half waits one beat
   always_ff @(posedge clk) begin
      if (ret_pop) begin
         app_rd_data <= ret_dout[line_width-1:sample_width];
         reply_lo <= ret_dout[sample_width-1:0];
      end else if (reply_phase == 2'd1) begin
         app_rd_data <= reply_lo;
      end
   end

   // the line pushed one cycle after acceptance must find room
   a_no_read_drop: assert property (@(posedge clk) disable iff (reset)
      rd_accept |=> (ret_level != rw'(p_ret_depth)))
      else $error("app_mem_model: read accepted with return fifo full");

   a_end_with_wren: assert property (@(posedge clk) disable iff (reset)
      app_wdf_end |-> app_wdf_wren)
      else $error("app_mem_model: app_wdf_end without app_wdf_wren");

endmodule

`default_nettype wire

/* src/capture_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_writer #(
   parameter int p_sample_depth = 16
) (
   input  wire                                   clk,
   input  wire                                   reset,
   input  wire                                   sample_valid,
   input  wire capture_pkg::sample_t             sample_data,
   input  wire                                   hold,
   input  wire                                   app_rdy,
   output logic [capture_pkg::addr_width-1:0]    app_addr,
   output logic [2:0]                            app_cmd,
   output logic                                  app_en,
   output capture_pkg::sample_t                  app_wdf_data,
   output logic                                  app_wdf_wren,
   output logic                                  app_wdf_end,
   output logic [capture_pkg::addr_width-1:0]    lines_written,
   output logic                                  overflow
);

   import capture_pkg::*;

   localparam int lw = $clog2(p_sample_depth + 1);

   sample_t fifo_dout;
   logic fifo_pop;
   logic [lw-1:0] fifo_level;
   logic write_start;
   logic in_beat2;

   // sample buffer, losses set the sticky flag
   sync_fifo #(
      .payload_t   (sample_t),
      .p_depth     (p_sample_depth),
      .p_threshold (p_sample_depth)
   ) u_sample_fifo (
      .clk         (clk),
      .reset       (reset),
      .wr_en       (sample_valid),
      .din         (sample_data),
      .rd_en       (fifo_pop),
      .dout        (fifo_dout),
      .empty       (),
      .level       (fifo_level),
      .nearly_full (),
      .overflow    (overflow)
   );

   // need a full pair queued, odd sample waits
   assign write_start = !in_beat2 && (fifo_level >= lw'(2)) && app_rdy && !hold;

   // head sample out on each beat, popped as it goes
   assign fifo_pop = write_start || in_beat2;
   assign app_en = fifo_pop;
   assign app_wdf_wren = fifo_pop;
   assign app_wdf_end = in_beat2;
   assign app_wdf_data = fifo_dout;
   assign app_cmd = cmd_write;

   always_ff @(posedge clk) begin
      if (reset) begin
         in_beat2 <= 1'b0;
         app_addr <= '0;
         lines_written <= '0;
      end else begin
         // beat 2 always follows beat 1
         in_beat2 <= write_start;
         if (in_beat2) begin
            app_addr <= app_addr + addr_width'(line_bytes);
            lines_written <= lines_written + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* src/readback_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module readback_reader (
   input  wire                                   clk,
   input  wire                                   reset,
   input  wire                                   start,
   input  wire [capture_pkg::addr_width-1:0]     line_count,
   input  wire                                   app_rdy,
   input  wire capture_pkg::sample_t             app_rd_data,
   input  wire                                   app_rd_data_valid,
   input  wire                                   app_rd_data_end,
   output logic [capture_pkg::addr_width-1:0]    app_addr,
   output logic [2:0]                            app_cmd,
   output logic                                  app_en,
   output logic                                  busy,
   output logic                                  out_valid,
   output capture_pkg::sample_t                  out_data,
   output logic                                  done
);

   import capture_pkg::*;

   logic [addr_width-1:0] reads_left;
   logic [addr_width-1:0] ends_left;
   logic rd_accept;

   // request every cycle until all lines issued
   assign app_en = busy && (reads_left != '0);
   assign app_cmd = cmd_read;
   assign rd_accept = app_en && app_rdy;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         reads_left <= '0;
         ends_left <= '0;
         app_addr <= '0;
         out_valid <= 1'b0;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         out_valid <= app_rd_data_valid;
         if (start && !busy) begin
            app_addr <= '0;
            reads_left <= line_count;
            ends_left <= line_count;
            // nothing stored, finish at once
            busy <= (line_count != '0);
            done <= (line_count == '0);
         end else if (busy) begin
            if (rd_accept) begin
               reads_left <= reads_left - 1'b1;
               app_addr <= app_addr + addr_width'(line_bytes);
            end
            // one end beat per line
            if (app_rd_data_valid && app_rd_data_end) begin
               ends_left <= ends_left - 1'b1;
               if (ends_left == addr_width'(1)) begin
                  busy <= 1'b0;
                  done <= 1'b1;
               end
            end
         end
      end
   end

   // beat data, one cycle behind
   always_ff @(posedge clk) begin
      out_data <= app_rd_data;
   end

   // replies only arrive for reads issued during a readback
   a_reply_in_readback: assert property (@(posedge clk) disable iff (reset)
      app_rd_data_valid |-> busy)
      else $error("readback_reader: read reply outside readback");

endmodule

`default_nettype wire

/* src/capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_top #(
   parameter int p_init_cycles = 64,
   parameter int p_sample_depth = 16,
   parameter int p_ret_depth = 8,
   parameter int p_ret_threshold = 6,
   parameter int p_mem_lines = 256
) (
   input  wire                                   clk,
   input  wire                                   reset,
   input  wire                                   sample_valid,
   input  wire capture_pkg::sample_t             sample_data,
   input  wire                                   start,
   output logic                                  out_valid,
   output capture_pkg::sample_t                  out_data,
   output logic                                  done,
   output logic [capture_pkg::addr_width-1:0]    lines_written,
   output logic                                  overflow,
   output logic                                  calib_done
);

   import capture_pkg::*;

   // app bus, shared
   logic [addr_width-1:0] app_addr;
   logic [2:0] app_cmd;
   logic app_en;
   sample_t app_wdf_data;
   logic app_wdf_wren;
   logic app_wdf_end;
   sample_t app_rd_data;
   logic app_rd_data_valid;
   logic app_rd_data_end;
   logic app_rdy;

   // writer side
   logic [addr_width-1:0] wr_addr;
   logic [2:0] wr_cmd;
   logic wr_en;
   logic wr_wren;
   logic wr_end;

   // reader side
   logic [addr_width-1:0] rd_addr;
   logic [2:0] rd_cmd;
   logic rd_en;
   logic busy;

   capture_writer #(
      .p_sample_depth (p_sample_depth)
   ) u_writer (
      .clk           (clk),
      .reset         (reset),
      .sample_valid  (sample_valid),
      .sample_data   (sample_data),
      .hold          (busy),
      .app_rdy       (app_rdy),
      .app_addr      (wr_addr),
      .app_cmd       (wr_cmd),
      .app_en        (wr_en),
      .app_wdf_data  (app_wdf_data),
      .app_wdf_wren  (wr_wren),
      .app_wdf_end   (wr_end),
      .lines_written (lines_written),
      .overflow      (overflow)
   );

   readback_reader u_reader (
      .clk               (clk),
      .reset             (reset),
      .start             (start),
      .line_count        (lines_written),
      .app_rdy           (app_rdy),
      .app_rd_data       (app_rd_data),
      .app_rd_data_valid (app_rd_data_valid),
      .app_rd_data_end   (app_rd_data_end),
      .app_addr          (rd_addr),
      .app_cmd           (rd_cmd),
      .app_en            (rd_en),
      .busy              (busy),
      .out_valid         (out_valid),
      .out_data          (out_data),
      .done              (done)
   );

   // reader owns the bus during readback
   assign app_addr = busy ? rd_addr : wr_addr;
   assign app_cmd = busy ? rd_cmd : wr_cmd;
   assign app_en = busy ? rd_en : wr_en;
   assign app_wdf_wren = wr_wren && !busy;
   assign app_wdf_end = wr_end && !busy;

   app_mem_model #(
      .p_init_cycles   (p_init_cycles),
      .p_ret_depth     (p_ret_depth),
      .p_ret_threshold (p_ret_threshold),
      .p_mem_lines     (p_mem_lines)
   ) u_mem (
      .clk                 (clk),
      .reset               (reset),
      .app_addr            (app_addr),
      .app_cmd             (app_cmd),
      .app_en              (app_en),
      .app_wdf_data        (app_wdf_data),
      .app_wdf_wren        (app_wdf_wren),
      .app_wdf_end         (app_wdf_end),
      .app_rd_data         (app_rd_data),
      .app_rd_data_valid   (app_rd_data_valid),
      .app_rd_data_end     (app_rd_data_end),
      .app_rdy             (app_rdy),
      .init_calib_complete (calib_done)
   );

endmodule

`default_nettype wire

/* verification/capture_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_checker #(
   parameter int p_init_cycles = 64
) (
   input  wire                                   clk,
   input  wire                                   reset,
   input  wire                                   sample_valid,
   input  wire capture_pkg::sample_t             sample_data,
   input  wire                                   start,
   input  wire                                   out_valid,
   input  wire capture_pkg::sample_t             out_data,
   input  wire                                   done,
   input  wire [capture_pkg::addr_width-1:0]     lines_written,
   input  wire                                   overflow,
   input  wire                                   calib_done,
   input  wire [capture_pkg::addr_width-1:0]     exp_lines,
   input  wire                                   exp_overflow,
   output int                                    error_count,
   output int                                    check_count
);

   import capture_pkg::*;

   // every sample offered at the input in arrival order
   sample_t sent_q[$];
   sample_t exp_sample;
   int returned;
   int errors = 0;
   int checks = 0;
   logic in_readback;
   int cal_cycles;
   logic exp_calib;

   assign error_count = errors;
   assign check_count = checks;

   // sampled on the falling edge where ports have settled
   always @(negedge clk) begin
      if (reset) begin
         sent_q.delete();
         returned = 0;
         in_readback = 1'b0;
         cal_cycles = 0;
      end else begin
         // calibration ends a fixed number of cycles after reset
         exp_calib = (cal_cycles >= p_init_cycles);
         if (calib_done !== exp_calib) begin
            $display("error calib_done: got %h expected %h", calib_done, exp_calib);
            errors++;
         end
         if (!exp_calib) begin
            cal_cycles++;
         end
         if (sample_valid) begin
            sent_q.push_back(sample_data);
         end
         if (start) begin
            in_readback = 1'b1;
         end
         // each returned beat against the oldest unmatched sample
         if (out_valid) begin
            checks++;
            if (!in_readback) begin
               $display("out_valid rose outside a readback");
               errors++;
            end else if (sent_q.size() == 0) begin
               $display("readback returned a sample that was never sent");
               errors++;
            end else begin
               exp_sample = sent_q.pop_front();
               if (out_data !== exp_sample) begin
                  $display("error out_data: got %h expected %h", out_data, exp_sample);
                  errors++;
               end
            end
            returned++;
         end
         // totals for the row at the end of readback
         if (done) begin
            checks++;
            if (!in_readback) begin
               $display("done pulsed outside a readback");
               errors++;
            end
            if (returned != 2 * int'(exp_lines)) begin
               $display("error out_valid count: got %h expected %h",
                        returned, 2 * int'(exp_lines));
               errors++;
            end
            if (lines_written !== exp_lines) begin
               $display("error lines_written: got %h expected %h", lines_written, exp_lines);
               errors++;
            end
            if (overflow !== exp_overflow) begin
               $display("error overflow: got %h expected %h", overflow, exp_overflow);
               errors++;
            end
            in_readback = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* verification/tb_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_capture;

   import capture_pkg::*;

   localparam int p_init_cycles = 64;
   localparam int p_sample_depth = 16;
   localparam int n_rows = 4;

   logic clk;
   logic reset;
   logic sample_valid;
   sample_t sample_data;
   logic start;
   logic out_valid;
   sample_t out_data;
   logic done;
   logic [addr_width-1:0] lines_written;
   logic overflow;
   logic calib_done;
   logic [addr_width-1:0] exp_lines;
   logic exp_overflow;
   int error_count;
   int check_count;
   int cycle_count = 0;
   int cycle_limit;
   logic [31:0] lcg_state;

   // sample count, gap cycles, wait for calibration, expected overflow
   int tab_count [n_rows] = '{8, 9, 40, p_sample_depth + 4};
   int tab_gap [n_rows] = '{3, 1, 0, 0};
   bit tab_wait_cal [n_rows] = '{1, 1, 1, 0};
   bit tab_overflow [n_rows] = '{0, 0, 0, 1};

   initial clk = 1'b0;
   always #4 clk = ~clk;

   capture_top #(
      .p_init_cycles   (p_init_cycles),
      .p_sample_depth  (p_sample_depth),
      .p_ret_depth     (8),
      .p_ret_threshold (6),
      .p_mem_lines     (256)
   ) uut (
      .clk           (clk),
      .reset         (reset),
      .sample_valid  (sample_valid),
      .sample_data   (sample_data),
      .start         (start),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .done          (done),
      .lines_written (lines_written),
      .overflow      (overflow),
      .calib_done    (calib_done)
   );

   capture_checker #(
      .p_init_cycles (p_init_cycles)
   ) chk (
      .clk           (clk),
      .reset         (reset),
      .sample_valid  (sample_valid),
      .sample_data   (sample_data),
      .start         (start),
      .out_valid     (out_valid),
      .out_data      (out_data),
      .done          (done),
      .lines_written (lines_written),
      .overflow      (overflow),
      .calib_done    (calib_done),
      .exp_lines     (exp_lines),
      .exp_overflow  (exp_overflow),
      .error_count   (error_count),
      .check_count   (check_count)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // per row reset, calibration, sending, readback and slack
   function automatic int run_limit();
      int total;
      total = 0;
      for (int i = 0; i < n_rows; i++) begin
         total += 10 + 2 * p_init_cycles + tab_count[i] * (tab_gap[i] + 1);
         total += 4 * tab_count[i] + 50;
      end
      return total;
   endfunction

   // inputs change just after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (10) next_cycle();
      reset = 1'b0;
   endtask

   task automatic send_samples(input int count, input int gap);
      for (int i = 0; i < count; i++) begin
         sample_valid = 1'b1;
         sample_data = lcg_state;
         lcg_state = lcg_next(lcg_state);
         next_cycle();
         sample_valid = 1'b0;
         repeat (gap) next_cycle();
      end
   endtask

   // hung run guard
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("timeout: run still going after %0d cycles", cycle_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      int accepted;
      reset = 1'b1;
      sample_valid = 1'b0;
      sample_data = '0;
      start = 1'b0;
      exp_lines = '0;
      exp_overflow = 1'b0;
      lcg_state = 32'hdd45af1b;
      cycle_limit = run_limit();
      for (int r = 0; r < n_rows; r++) begin
         // overflowing rows keep only what fits in the sample fifo
         accepted = tab_overflow[r] ? p_sample_depth : tab_count[r];
         // odd sample never forms a line
         exp_lines = addr_width'(accepted / 2);
         exp_overflow = tab_overflow[r];
         apply_reset();
         if (tab_wait_cal[r]) begin
            while (!calib_done) begin
               next_cycle();
            end
         end
         send_samples(tab_count[r], tab_gap[r]);
         while (lines_written != exp_lines) begin
            next_cycle();
         end
         start = 1'b1;
         next_cycle();
         start = 1'b0;
         while (!done) begin
            next_cycle();
         end
         // catch a second done or stray beats
         repeat (8) next_cycle();
      end
      $display("checks: %0d errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* capture.f */
src/capture_pkg.sv
src/sync_fifo.sv
src/app_mem_model.sv
src/capture_writer.sv
src/readback_reader.sv
src/capture_top.sv
verification/capture_checker.sv
verification/tb_capture.sv

/* Makefile */
OBJ = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tb_capture -f capture.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_capture \
		-Mdir $(OBJ) -f capture.f
	./$(OBJ)/Vtb_capture | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
